/* Makefile */
SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

obj_dir/Vtb_rv_core: rv_core.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core -f rv_core.f

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core

clean:
	rm -rf obj_dir

.PHONY: run clean

/* rv_core.f */
+incdir+test
src/rv_pkg.sv
src/alu.sv
src/decoder.sv
src/execute.sv
src/reg_file.sv
src/core_control.sv
src/rv_core.sv
test/tb_rv_core.sv

/* src/alu.sv */
`timescale 1ns/10ps

module alu (
   input  rv_pkg::instructions instr,
   input  rv_pkg::xlen_t       pc,
   input  rv_pkg::xlen_t       rs1_v,
   input  rv_pkg::xlen_t       rs2_v,
   input  rv_pkg::xlen_t       imm,
   output rv_pkg::xlen_t       result
);
   import rv_pkg::*;

   logic [4:0] shamt_i;
   logic [4:0] shamt_r;

   assign shamt_i = imm[4:0];
   assign shamt_r = rs2_v[4:0];

   always_comb begin
      result = '0;
      case (1'b1)
         instr.lui:    result = imm;
         instr.auipc:  result = pc + imm;
         instr.jalr:   result = (rs1_v + imm) & ~32'd1;
         // Branches report the condition in bit 0
         instr.beq:    result = {31'b0, rs1_v == rs2_v};
         instr.bne:    result = {31'b0, rs1_v != rs2_v};
         instr.blt:    result = {31'b0, $signed(rs1_v) < $signed(rs2_v)};
         instr.bge:    result = {31'b0, $signed(rs1_v) >= $signed(rs2_v)};
         instr.bltu:   result = {31'b0, rs1_v < rs2_v};
         instr.bgeu:   result = {31'b0, rs1_v >= rs2_v};
         instr.lw,
         instr.sw,
         instr.addi:   result = rs1_v + imm;
         instr.slti:   result = {31'b0, $signed(rs1_v) < $signed(imm)};
         instr.sltiu:  result = {31'b0, rs1_v < imm};
         instr.xori:   result = rs1_v ^ imm;
         instr.ori:    result = rs1_v | imm;
         instr.andi:   result = rs1_v & imm;
         instr.slli:   result = rs1_v << shamt_i;
         instr.srli:   result = rs1_v >> shamt_i;
         instr.srai:   result = $signed(rs1_v) >>> shamt_i;
         instr.add:    result = rs1_v + rs2_v;
         instr.sub:    result = rs1_v - rs2_v;
         instr.sll:    result = rs1_v << shamt_r;
         instr.slt:    result = {31'b0, $signed(rs1_v) < $signed(rs2_v)};
         instr.sltu:   result = {31'b0, rs1_v < rs2_v};
         instr.xor_op: result = rs1_v ^ rs2_v;
         instr.srl:    result = rs1_v >> shamt_r;
         instr.sra:    result = $signed(rs1_v) >>> shamt_r;
         instr.or_op:  result = rs1_v | rs2_v;
         instr.and_op: result = rs1_v & rs2_v;
         default:      result = '0;
      endcase
   end

endmodule

/* src/core_control.sv */
`timescale 1ns/10ps

module core_control (
   input  logic              clk,
   input  logic              reset,
   output rv_pkg::xlen_t     imem_addr,
   input  rv_pkg::xlen_t     imem_data,
   output rv_pkg::xlen_t     ir,
   output rv_pkg::xlen_t     pc,
   output logic              exec_en,
   input  rv_pkg::exec_out_t ex,
   output logic              rf_wen,
   output rv_pkg::xlen_t     rf_wdata,
   output rv_pkg::dmem_req_t dmem_req,
   input  rv_pkg::dmem_rsp_t dmem_rsp,
   output rv_pkg::retire_t   retire
);
   import rv_pkg::*;

   core_state_t state;
   core_state_t state_next;
   exec_out_t   ex_hold;
   exec_out_t   ex_cur;
   xlen_t       load_data;
   logic        ex_fresh;
   logic        outstanding;
   logic        is_mem_op;

   // Word loads and stores take the MEM detour
   assign is_mem_op = (ir[6:0] == OP_LOAD || ir[6:0] == OP_STORE) && (ir[14:12] == F3_WORD);

   always_comb begin
      case (state)
         FETCH:   state_next = DECODE;
         DECODE:  state_next = EXEC;
         EXEC:    state_next = is_mem_op ? MEM : WB;
         MEM:     state_next = (dmem_rsp.valid && outstanding) ? WB : MEM;
         default: state_next = FETCH;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= FETCH;
         pc          <= RESET_PC;
         ir          <= '0;
         ex_fresh    <= 1'b0;
         outstanding <= 1'b0;
      end else begin
         state    <= state_next;
         ex_fresh <= exec_en;
         if (state == FETCH)
            ir <= imem_data;
         if (state == WB)
            pc <= ex_cur.jump ? ex_cur.jump_dest : pc + 32'd4;
         if (dmem_req.valid)
            outstanding <= 1'b1;
         else if (dmem_rsp.valid)
            outstanding <= 1'b0;
      end
   end

   // Execute clears its flags one cycle after EXEC, so keep a copy for MEM and WB
   always_ff @(posedge clk) begin
      if (ex_fresh)
         ex_hold <= ex;
      if (state == MEM && dmem_rsp.valid)
         load_data <= dmem_rsp.rdata;
   end

   assign ex_cur    = ex_fresh ? ex : ex_hold;
   assign imem_addr = pc;
   assign exec_en   = (state == EXEC);

   assign dmem_req.valid = (state == MEM) && ex_fresh;
   assign dmem_req.write = ex_cur.mem_write;
   assign dmem_req.addr  = ex_cur.mem_target;
   assign dmem_req.wdata = ex_cur.result;

   assign rf_wen   = (state == WB) && ex_cur.reg_write;
   assign rf_wdata = ex_cur.mem_read ? load_data : ex_cur.result;

   assign retire.valid = (state == WB);
   assign retire.pc    = pc;
   assign retire.rd    = ex_cur.reg_dest;
   assign retire.wen   = rf_wen;
   assign retire.value = rf_wdata;

   a_mem_exit: assert property (@(posedge clk) disable iff (reset)
      ($past(state) == MEM && state != MEM) |-> $past(dmem_rsp.valid));

   a_one_req: assert property (@(posedge clk) disable iff (reset)
      dmem_req.valid |-> !outstanding);

endmodule

/* src/decoder.sv */
`timescale 1ns/10ps

module decoder (
   input  rv_pkg::xlen_t       ir,
   output rv_pkg::instructions instr,
   output rv_pkg::reg_idx_t    rd,
   output rv_pkg::reg_idx_t    rs1,
   output rv_pkg::reg_idx_t    rs2,
   output rv_pkg::xlen_t       imm
);
   import rv_pkg::*;

   opcode_t    opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = ir[6:0];
   assign funct3 = ir[14:12];
   assign funct7 = ir[31:25];
   assign rd     = ir[11:7];
   assign rs1    = ir[19:15];
   assign rs2    = ir[24:20];

   always_comb begin
      instr = '0;
      case (opcode)
         OP_LUI:   instr.lui = 1'b1;
         OP_AUIPC: instr.auipc = 1'b1;
         OP_JAL:   instr.jal = 1'b1;
         OP_JALR:  instr.jalr = (funct3 == 3'b000);
         OP_LOAD:  instr.lw = (funct3 == F3_WORD);
         OP_STORE: instr.sw = (funct3 == F3_WORD);
         OP_BRANCH: begin
            instr.beq  = (funct3 == 3'b000);
            instr.bne  = (funct3 == 3'b001);
            instr.blt  = (funct3 == 3'b100);
            instr.bge  = (funct3 == 3'b101);
            instr.bltu = (funct3 == 3'b110);
            instr.bgeu = (funct3 == 3'b111);
         end
         OP_IMM: begin
            instr.addi  = (funct3 == 3'b000);
            instr.slti  = (funct3 == 3'b010);
            instr.sltiu = (funct3 == 3'b011);
            instr.xori  = (funct3 == 3'b100);
            instr.ori   = (funct3 == 3'b110);
            instr.andi  = (funct3 == 3'b111);
            // Shift immediates also qualify on funct7
            instr.slli  = (funct3 == 3'b001) && (funct7 == 7'b0000000);
            instr.srli  = (funct3 == 3'b101) && (funct7 == 7'b0000000);
            instr.srai  = (funct3 == 3'b101) && (funct7 == 7'b0100000);
         end
         OP_REG: begin
            instr.add    = ({funct7, funct3} == 10'b0000000_000);
            instr.sub    = ({funct7, funct3} == 10'b0100000_000);
            instr.sll    = ({funct7, funct3} == 10'b0000000_001);
            instr.slt    = ({funct7, funct3} == 10'b0000000_010);
            instr.sltu   = ({funct7, funct3} == 10'b0000000_011);
            instr.xor_op = ({funct7, funct3} == 10'b0000000_100);
            instr.srl    = ({funct7, funct3} == 10'b0000000_101);
            instr.sra    = ({funct7, funct3} == 10'b0100000_101);
            instr.or_op  = ({funct7, funct3} == 10'b0000000_110);
            instr.and_op = ({funct7, funct3} == 10'b0000000_111);
         end
         default: instr = '0;
      endcase
   end

   always_comb begin
      case (opcode)
         OP_STORE:         imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
         OP_BRANCH:        imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
         OP_LUI, OP_AUIPC: imm = {ir[31:12], 12'b0};
         OP_JAL:           imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
         default:          imm = {{20{ir[31]}}, ir[31:20]};
      endcase
   end

   // Decode table must never match two rows
   always_comb begin
      assert ($onehot0(instr));
   end

endmodule

/* src/execute.sv */
`timescale 1ns/10ps

module execute (
   input  logic                clk,
   input  logic                reset,
   input  logic                exec_en,
   input  rv_pkg::xlen_t       pc,
   input  rv_pkg::instructions instr,
   input  rv_pkg::reg_idx_t    rd,
   input  rv_pkg::xlen_t       rs1_v,
   input  rv_pkg::xlen_t       rs2_v,
   input  rv_pkg::xlen_t       imm,
   output rv_pkg::exec_out_t   ex
);
   import rv_pkg::*;

   xlen_t alu_result;
   logic  is_branch;
   logic  is_valid;

   alu alu_i (
      .instr  (instr),
      .pc     (pc),
      .rs1_v  (rs1_v),
      .rs2_v  (rs2_v),
      .imm    (imm),
      .result (alu_result)
   );

   assign is_branch = instr.beq | instr.bne | instr.blt | instr.bge | instr.bltu | instr.bgeu;
   assign is_valid  = |instr;

   always_ff @(posedge clk) begin
      if (reset) begin
         ex.mem_read  <= 1'b0;
         ex.mem_write <= 1'b0;
         ex.reg_write <= 1'b0;
         ex.jump      <= 1'b0;
      end else if (exec_en) begin
         ex.mem_read   <= instr.lw;
         ex.mem_write  <= instr.sw;
         ex.mem_target <= alu_result;
         // No-op words and x0 destinations leave the register file alone
         ex.reg_write  <= is_valid && !is_branch && !instr.sw && (rd != 5'd0);
         ex.reg_dest   <= rd;
         ex.jump       <= instr.jal | instr.jalr | (is_branch & alu_result[0]);
         ex.jump_dest  <= instr.jalr ? alu_result : pc + imm;
         if (instr.jal || instr.jalr)
            ex.result <= pc + 32'd4;
         else if (instr.sw)
            ex.result <= rs2_v;
         else
            ex.result <= alu_result;
      end else begin
         ex.mem_read  <= 1'b0;
         ex.mem_write <= 1'b0;
         ex.reg_write <= 1'b0;
         ex.jump      <= 1'b0;
      end
   end

   a_mem_kind: assert property (@(posedge clk) disable iff (reset)
      exec_en |=> !(ex.mem_read && ex.mem_write));

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
   input  logic             clk,
   input  logic             reset,
   input  rv_pkg::reg_idx_t rs1,
   input  rv_pkg::reg_idx_t rs2,
   input  rv_pkg::reg_idx_t rd,
   input  logic             wen,
   input  rv_pkg::xlen_t    wdata,
   output rv_pkg::xlen_t    rs1_v,
   output rv_pkg::xlen_t    rs2_v
);
   import rv_pkg::*;

   xlen_t regs [0:31];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 32; i++)
            regs[i] <= '0;
      end else if (wen && rd != 5'd0) begin
         regs[rd] <= wdata;
      end
   end

   // x0 is never written so it reads back as zero
   assign rs1_v = regs[rs1];
   assign rs2_v = regs[rs2];

endmodule

/* src/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
   input  logic              clk,
   input  logic              reset,
   output rv_pkg::xlen_t     imem_addr,
   input  rv_pkg::xlen_t     imem_data,
   output rv_pkg::dmem_req_t dmem_req,
   input  rv_pkg::dmem_rsp_t dmem_rsp,
   output rv_pkg::retire_t   retire
);
   import rv_pkg::*;

   xlen_t       ir;
   xlen_t       pc;
   xlen_t       imm;
   xlen_t       rs1_v;
   xlen_t       rs2_v;
   xlen_t       rf_wdata;
   reg_idx_t    rd;
   reg_idx_t    rs1;
   reg_idx_t    rs2;
   instructions instr;
   exec_out_t   ex;
   logic        exec_en;
   logic        rf_wen;

   core_control core_control_i (
      .clk       (clk),
      .reset     (reset),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .ir        (ir),
      .pc        (pc),
      .exec_en   (exec_en),
      .ex        (ex),
      .rf_wen    (rf_wen),
      .rf_wdata  (rf_wdata),
      .dmem_req  (dmem_req),
      .dmem_rsp  (dmem_rsp),
      .retire    (retire)
   );

   decoder decoder_i (
      .ir    (ir),
      .instr (instr),
      .rd    (rd),
      .rs1   (rs1),
      .rs2   (rs2),
      .imm   (imm)
   );

   // Write port takes its index from the registered execute record
   reg_file reg_file_i (
      .clk   (clk),
      .reset (reset),
      .rs1   (rs1),
      .rs2   (rs2),
      .rd    (retire.rd),
      .wen   (rf_wen),
      .wdata (rf_wdata),
      .rs1_v (rs1_v),
      .rs2_v (rs2_v)
   );

   execute execute_i (
      .clk     (clk),
      .reset   (reset),
      .exec_en (exec_en),
      .pc      (pc),
      .instr   (instr),
      .rd      (rd),
      .rs1_v   (rs1_v),
      .rs2_v   (rs2_v),
      .imm     (imm),
      .ex      (ex)
   );

endmodule

/* src/rv_pkg.sv */
package rv_pkg;

   typedef logic [31:0] xlen_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [6:0]  opcode_t;

   localparam xlen_t RESET_PC = 32'h0000_0000;

   // Major opcodes of the supported subset
   localparam opcode_t OP_LUI    = 7'b0110111;
   localparam opcode_t OP_AUIPC  = 7'b0010111;
   localparam opcode_t OP_JAL    = 7'b1101111;
   localparam opcode_t OP_JALR   = 7'b1100111;
   localparam opcode_t OP_BRANCH = 7'b1100011;
   localparam opcode_t OP_LOAD   = 7'b0000011;
   localparam opcode_t OP_STORE  = 7'b0100011;
   localparam opcode_t OP_IMM    = 7'b0010011;
   localparam opcode_t OP_REG    = 7'b0110011;

   localparam logic [2:0] F3_WORD = 3'b010;

   // One flag per instruction, all clear for an unsupported word
   typedef struct packed {
      logic lui, auipc, jal, jalr;
      logic beq, bne, blt, bge, bltu, bgeu;
      logic lw, sw;
      logic addi, slti, sltiu, xori, ori, andi;
      logic slli, srli, srai;
      logic add, sub, sll, slt, sltu;
      logic xor_op, srl, sra, or_op, and_op;
   } instructions;

   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXEC,
      MEM,
      WB
   } core_state_t;

   typedef struct packed {
      xlen_t    result;
      logic     mem_read;
      logic     mem_write;
      xlen_t    mem_target;
      logic     reg_write;
      reg_idx_t reg_dest;
      logic     jump;
      xlen_t    jump_dest;
   } exec_out_t;

   typedef struct packed {
      logic  valid;
      logic  write;
      xlen_t addr;
      xlen_t wdata;
   } dmem_req_t;

   typedef struct packed {
      logic  valid;
      xlen_t rdata;
   } dmem_rsp_t;

   typedef struct packed {
      logic     valid;
      xlen_t    pc;
      reg_idx_t rd;
      logic     wen;
      xlen_t    value;
   } retire_t;

endpackage

/* test/ref_model.svh */
xlen_t imem [0:511];
xlen_t data_mem [0:63];
xlen_t model_mem [0:63];
xlen_t model_regs [0:31];
xlen_t model_pc;

function automatic xlen_t fill_word(int idx);
   return 32'hc3a5_0000 ^ (idx * 32'h0001_0207) ^ {idx[7:0], 24'h0};
endfunction

function automatic xlen_t random_instr();
   xlen_t off;
   xlen_t mem_off;
   logic [4:0] rd;
   logic [4:0] rs1;
   logic [4:0] rs2;
   logic [2:0] f3;
   logic [6:0] f7;
   logic [11:0] imm;
   int unsigned kind;
   rd = 5'($urandom);
   rs1 = 5'($urandom);
   rs2 = 5'($urandom);
   f3 = 3'($urandom);
   f7 = ($urandom % 2 == 1) ? 7'b0100000 : 7'b0000000;
   imm = 12'($urandom);
   kind = $urandom % 9;
   // Forward offsets of 4 to 32 bytes, word offsets into the 64-word data memory
   off = (($urandom % 8) + 1) << 2;
   mem_off = ($urandom % 64) << 2;
   case (kind)
      0: begin
         if (f3 != 3'd0 && f3 != 3'd5)
            f7 = 7'b0000000;
         return {f7, rs2, rs1, f3, rd, OP_REG};
      end
      1, 2: begin
         if (f3 == 3'd1)
            imm = {7'b0000000, imm[4:0]};
         if (f3 == 3'd5)
            imm = {f7, imm[4:0]};
         return {imm, rs1, f3, rd, OP_IMM};
      end
      3: return {20'($urandom), rd, ($urandom % 2 == 1) ? OP_LUI : OP_AUIPC};
      4: return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
      5: return {mem_off[11:0], 5'd0, 3'b000, rd, OP_JALR};
      6: begin
         // funct3 2 and 3 are not branches
         if (f3 == 3'd2 || f3 == 3'd3)
            f3 = f3 + 3'd4;
         return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
      end
      7: return {mem_off[11:0], 5'd0, F3_WORD, rd, OP_LOAD};
      default: return {mem_off[11:5], rs2, 5'd0, F3_WORD, mem_off[4:0], OP_STORE};
   endcase
endfunction

task automatic init_memories();
   for (int i = 0; i < 512; i++)
      imem[i] = random_instr();
   for (int i = 0; i < 64; i++) begin
      data_mem[i] = fill_word(i);
      model_mem[i] = fill_word(i);
   end
   for (int i = 0; i < 32; i++)
      model_regs[i] = '0;
   model_pc = RESET_PC;
endtask

function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b);
   case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
   endcase
endfunction

function automatic xlen_t model_alu(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
   case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
         if (alt)
            return $signed(a) >>> b[4:0];
         return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
   endcase
endfunction

// Runs one instruction of the program and reports what should retire
task automatic model_step(output xlen_t pc_o, output reg_idx_t rd_o, output logic wen_o,
                          output xlen_t val_o);
   xlen_t ins;
   xlen_t a;
   xlen_t b;
   xlen_t i_imm;
   xlen_t s_imm;
   xlen_t b_imm;
   xlen_t j_imm;
   xlen_t addr;
   xlen_t next_pc;
   logic [2:0] f3;
   logic writes;
   ins = imem[model_pc[10:2]];
   f3 = ins[14:12];
   a = model_regs[ins[19:15]];
   b = model_regs[ins[24:20]];
   i_imm = {{20{ins[31]}}, ins[31:20]};
   s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
   b_imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
   j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
   next_pc = model_pc + 32'd4;
   val_o = '0;
   writes = 1'b1;
   case (ins[6:0])
      OP_LUI:   val_o = {ins[31:12], 12'b0};
      OP_AUIPC: val_o = model_pc + {ins[31:12], 12'b0};
      OP_JAL: begin
         val_o = next_pc;
         next_pc = model_pc + j_imm;
      end
      OP_JALR: begin
         val_o = next_pc;
         next_pc = (a + i_imm) & ~32'd1;
      end
      OP_BRANCH: begin
         writes = 1'b0;
         if (branch_taken(f3, a, b))
            next_pc = model_pc + b_imm;
      end
      OP_LOAD: begin
         addr = a + i_imm;
         val_o = model_mem[addr[7:2]];
      end
      OP_STORE: begin
         writes = 1'b0;
         addr = a + s_imm;
         model_mem[addr[7:2]] = b;
      end
      OP_IMM:  val_o = model_alu(f3, ins[30] && f3 == 3'd5, a, i_imm);
      default: val_o = model_alu(f3, ins[30], a, b);
   endcase
   pc_o = model_pc;
   rd_o = ins[11:7];
   wen_o = writes && (rd_o != 5'd0);
   if (wen_o)
      model_regs[rd_o] = val_o;
   model_pc = next_pc;
endtask

/* test/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;
   import rv_pkg::*;

   localparam int NUM_RETIRE = 200;
   // Slowest instruction is well under ten cycles
   localparam int TIMEOUT_CYCLES = NUM_RETIRE * 10;

   logic      clk;
   logic      reset;
   xlen_t     imem_addr;
   xlen_t     imem_data;
   dmem_req_t dmem_req;
   dmem_rsp_t dmem_rsp;
   retire_t   retire;

   dmem_req_t   pend_req;
   int unsigned rsp_wait;
   int          retired_count;
   int          cycle_count;
   xlen_t       exp_pc;
   xlen_t       exp_val;
   reg_idx_t    exp_rd;
   logic        exp_wen;

   `include "ref_model.svh"

   rv_core dut_i (
      .clk       (clk),
      .reset     (reset),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .dmem_req  (dmem_req),
      .dmem_rsp  (dmem_rsp),
      .retire    (retire)
   );

   assign imem_data = imem[imem_addr[10:2]];

   always #20 clk = ~clk;

   task automatic check_equal(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
         $display("Verification failed");
         $fatal(1, "value mismatch");
      end
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      dmem_rsp = '0;
      pend_req = '0;
      rsp_wait = 0;
      retired_count = 0;
      cycle_count = 0;
      void'($urandom(32'h6f19e0d8));
      init_memories();
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      wait (retired_count == NUM_RETIRE);
      $display("Verification passed");
      $finish;
   end

   // Data port responder with a random delay of 1 to 3 cycles
   always @(negedge clk) begin
      if (!reset) begin
         // Base x0 and offsets 0 to 252 keep every access inside the word window
         if (dmem_req.valid) begin
            check_equal("cycles left on the pending data request", rsp_wait, 32'd0);
            check_equal("data address bits outside the window",
                        dmem_req.addr & ~32'h0000_00fc, 32'd0);
         end
         dmem_rsp.valid = 1'b0;
         if (rsp_wait != 0) begin
            rsp_wait = rsp_wait - 1;
            if (rsp_wait == 0) begin
               if (pend_req.write)
                  data_mem[pend_req.addr[7:2]] = pend_req.wdata;
               dmem_rsp.rdata = data_mem[pend_req.addr[7:2]];
               dmem_rsp.valid = 1'b1;
            end
         end
         if (dmem_req.valid) begin
            pend_req = dmem_req;
            rsp_wait = ($urandom % 3) + 1;
         end
      end
   end

   always @(negedge clk) begin
      if (!reset && retire.valid) begin
         model_step(exp_pc, exp_rd, exp_wen, exp_val);
         check_equal("retire pc", retire.pc, exp_pc);
         check_equal("retire wen", {31'b0, retire.wen}, {31'b0, exp_wen});
         check_equal("retire rd", {27'b0, retire.rd}, {27'b0, exp_rd});
         if (exp_wen)
            check_equal("retire value", retire.value, exp_val);
         retired_count = retired_count + 1;
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         cycle_count = cycle_count + 1;
         if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the core stopped retiring after %0d of %0d instructions",
                     retired_count, NUM_RETIRE);
            $display("Verification failed");
            $fatal(1, "simulation timeout");
         end
      end
   end

endmodule
